// File: action_entry_assembler.sv
module action_entry_assembler (
    input  logic                 clk,
    input  logic                 rst_n,

    input  lke_pkg::ctrl_beat_t  entry_beat,
    input  logic                 entry_start,
    input  lke_pkg::tbl_addr_t   entry_index,
    output logic                 busy,

    output logic                 wr_en,
    output lke_pkg::tbl_addr_t   wr_addr,
    output lke_pkg::action_t     wr_data
);

    logic [1:0]                      beat_cnt;
    logic [lke_pkg::CTRL_DATA_W-1:0] swapped;
    logic                            take;

    // little endian stream to big endian entry
    always_comb begin
        for (int i = 0; i < lke_pkg::CTRL_BYTES; i++) begin
            swapped[8*i +: 8] = entry_beat.tdata[lke_pkg::CTRL_DATA_W-8-8*i +: 8];
        end
    end

    assign take = busy && entry_beat.tvalid;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            busy     <= 1'b0;
            beat_cnt <= '0;
            wr_en    <= 1'b0;
        end else begin
            wr_en <= 1'b0;
            if (entry_start) begin
                busy     <= 1'b1;
                beat_cnt <= '0;
            end else if (take) begin
                beat_cnt <= beat_cnt + 2'd1;
                if (beat_cnt == 2'd2) begin
                    busy  <= 1'b0;
                    wr_en <= 1'b1;
                end
            end
        end
    end

    // entry is built top down
    always_ff @(posedge clk) begin
        if (entry_start) begin
            wr_addr <= entry_index;
        end
        if (take) begin
            case (beat_cnt)
                2'd0: wr_data[lke_pkg::ACT_W-1 -: lke_pkg::CTRL_DATA_W] <= swapped;
                2'd1: wr_data[lke_pkg::ENTRY_TAIL_W +: lke_pkg::CTRL_DATA_W] <= swapped;
                default: wr_data[0 +: lke_pkg::ENTRY_TAIL_W] <=
                    swapped[lke_pkg::CTRL_DATA_W-1 -: lke_pkg::ENTRY_TAIL_W];
            endcase
        end
    end

endmodule

// File: action_ram.sv
module action_ram (
    input  logic                clk,

    input  logic                wr_en,
    input  lke_pkg::tbl_addr_t  wr_addr,
    input  lke_pkg::action_t    wr_data,

    input  lke_pkg::tbl_addr_t  rd_addr,
    output lke_pkg::action_t    rd_data
);

    lke_pkg::action_t mem [lke_pkg::TBL_DEPTH];

    // write port
    always_ff @(posedge clk) begin
        if (wr_en) begin
            mem[wr_addr] <= wr_data;
        end
    end

    // registered read, old data on a same-address write
    always_ff @(posedge clk) begin
        rd_data <= mem[rd_addr];
    end

endmodule

// File: ctrl_filter.sv
module ctrl_filter (
    input  logic                 clk,
    input  logic                 rst_n,

    input  lke_pkg::ctrl_beat_t  c_s,
    output lke_pkg::ctrl_beat_t  c_m,

    output lke_pkg::ctrl_beat_t  entry_beat,
    output logic                 entry_start,
    output lke_pkg::tbl_addr_t   entry_index,
    input  logic                 busy
);

    lke_pkg::ctrl_state_t state;
    lke_pkg::ctrl_beat_t  first_beat;
    lke_pkg::ctrl_beat_t  beat_d1;

    logic [lke_pkg::MOD_ID_W-1:0] mod_id;
    logic [lke_pkg::RESV_W-1:0]   resv;
    logic [lke_pkg::FLAG_W-1:0]   flag;
    logic                         hdr_match;
    logic                         can_take;

    // ==========================================================================
    // header decode, valid only while c_s carries the second beat
    // ==========================================================================
    assign mod_id = c_s.tdata[lke_pkg::MOD_ID_LSB +: lke_pkg::MOD_ID_W];
    assign resv   = c_s.tdata[lke_pkg::RESV_LSB +: lke_pkg::RESV_W];
    assign flag   = c_s.tdata[lke_pkg::FLAG_LSB +: lke_pkg::FLAG_W];

    assign hdr_match = (mod_id[lke_pkg::MOD_ID_W-1 -: lke_pkg::STAGE_W] == lke_pkg::STAGE_ID)
                    && (mod_id[lke_pkg::LOOKUP_W-1:0] == lke_pkg::LOOKUP_ID)
                    && (flag == lke_pkg::CTRL_MAGIC)
                    && (resv != '0);

    // ready for the first beat of a new packet
    assign can_take = (state == lke_pkg::CTRL_IDLE)
                   || (state == lke_pkg::CTRL_FLUSH && beat_d1.tvalid && beat_d1.tlast)
                   || (state == lke_pkg::CTRL_LOAD && !busy);

    assign entry_start = (state == lke_pkg::CTRL_PARSE) && c_s.tvalid && hdr_match;
    assign entry_index = c_s.tdata[lke_pkg::INDEX_LSB +: lke_pkg::TBL_ADDR_W];

    // entry beats reach the assembler only while loading
    always_comb begin
        entry_beat        = c_s;
        entry_beat.tvalid = c_s.tvalid && (state == lke_pkg::CTRL_LOAD);
    end

    always_ff @(posedge clk) begin
        beat_d1 <= c_s;
        if (can_take && c_s.tvalid) begin
            first_beat <= c_s;
        end
    end

    // ==========================================================================
    // classify, hold, forward
    // ==========================================================================
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state <= lke_pkg::CTRL_IDLE;
            c_m   <= '0;
        end else begin
            c_m <= '0;
            case (state)
                lke_pkg::CTRL_PARSE: begin
                    if (c_s.tvalid) begin
                        if (hdr_match) begin
                            state <= lke_pkg::CTRL_LOAD;
                        end else begin
                            c_m   <= first_beat;
                            state <= lke_pkg::CTRL_FLUSH;
                        end
                    end
                end
                lke_pkg::CTRL_FLUSH: begin
                    c_m <= beat_d1;
                end
                default: begin
                end
            endcase
            // a new packet may start right behind the last one
            if (can_take) begin
                state <= c_s.tvalid ? lke_pkg::CTRL_PARSE : lke_pkg::CTRL_IDLE;
            end
        end
    end

endmodule

// File: lke_pkg.sv
package lke_pkg;

    // ==========================================================================
    // widths
    // ==========================================================================
    localparam int PHV_W        = 1124;
    localparam int ACT_W        = 625;
    localparam int VLAN_W       = 12;
    localparam int TBL_ADDR_W   = 4;
    localparam int TBL_DEPTH    = 1 << TBL_ADDR_W;
    localparam int CTRL_DATA_W  = 256;
    localparam int CTRL_USER_W  = 128;
    localparam int CTRL_BYTES   = CTRL_DATA_W / 8;
    // last entry beat only fills what the first two leave over
    localparam int ENTRY_TAIL_W = ACT_W - 2 * CTRL_DATA_W;

    typedef logic [PHV_W-1:0]      phv_t;
    typedef logic [ACT_W-1:0]      action_t;
    typedef logic [VLAN_W-1:0]     vlan_id_t;
    typedef logic [TBL_ADDR_W-1:0] tbl_addr_t;

    // one beat of the control stream
    typedef struct packed {
        logic [CTRL_DATA_W-1:0] tdata;
        logic [CTRL_USER_W-1:0] tuser;
        logic [CTRL_BYTES-1:0]  tkeep;
        logic                   tvalid;
        logic                   tlast;
    } ctrl_beat_t;

    // ==========================================================================
    // stage constants
    // ==========================================================================
    localparam int VLAN_LSB = 129;
    localparam int STAGE_W  = 5;
    localparam int LOOKUP_W = 3;
    localparam int MOD_ID_W = STAGE_W + LOOKUP_W;
    localparam int RESV_W   = 4;
    localparam int FLAG_W   = 16;

    localparam logic [STAGE_W-1:0]  STAGE_ID   = 5'd0;
    localparam logic [LOOKUP_W-1:0] LOOKUP_ID  = 3'd2;
    localparam logic [FLAG_W-1:0]   CTRL_MAGIC = 16'hf2f1;

    localparam action_t DEFAULT_ACTION = action_t'('h3f);

    // header fields, second control beat
    localparam int FLAG_LSB   = 64;
    localparam int MOD_ID_LSB = 112;
    localparam int RESV_LSB   = 120;
    localparam int INDEX_LSB  = 128;

    typedef enum logic [1:0] {
        CTRL_IDLE,
        CTRL_PARSE,
        CTRL_LOAD,
        CTRL_FLUSH
    } ctrl_state_t;

    typedef enum logic [1:0] {
        LK_IDLE,
        LK_WAIT,
        LK_HALT
    } lookup_state_t;

endpackage

// File: lke_ram_stage.sv
module lke_ram_stage (
    input  logic                 clk,
    input  logic                 rst_n,

    // from key extractor
    input  lke_pkg::phv_t        phv_in,
    input  logic                 phv_valid,
    input  lke_pkg::tbl_addr_t   match_addr,
    input  logic                 if_match,
    output logic                 ready_out,

    // to action engine
    output lke_pkg::action_t     action,
    output logic                 action_valid,
    output lke_pkg::phv_t        phv_out,
    input  logic                 ready_in,

    output lke_pkg::vlan_id_t    act_vlan_out,
    output logic                 act_vlan_out_valid,
    input  logic                 act_vlan_ready,

    // control stream
    input  lke_pkg::ctrl_beat_t  c_s,
    output lke_pkg::ctrl_beat_t  c_m
);

    lke_pkg::ctrl_beat_t entry_beat;
    logic                entry_start;
    lke_pkg::tbl_addr_t  entry_index;
    logic                busy;
    logic                wr_en;
    lke_pkg::tbl_addr_t  wr_addr;
    lke_pkg::action_t    wr_data;
    lke_pkg::tbl_addr_t  rd_addr;
    lke_pkg::action_t    rd_data;

    // ==========================================================================
    // control path
    // ==========================================================================
    ctrl_filter u_ctrl_filter (
        .clk         (clk),
        .rst_n       (rst_n),
        .c_s         (c_s),
        .c_m         (c_m),
        .entry_beat  (entry_beat),
        .entry_start (entry_start),
        .entry_index (entry_index),
        .busy        (busy)
    );

    action_entry_assembler u_assembler (
        .clk         (clk),
        .rst_n       (rst_n),
        .entry_beat  (entry_beat),
        .entry_start (entry_start),
        .entry_index (entry_index),
        .busy        (busy),
        .wr_en       (wr_en),
        .wr_addr     (wr_addr),
        .wr_data     (wr_data)
    );

    action_ram u_action_ram (
        .clk     (clk),
        .wr_en   (wr_en),
        .wr_addr (wr_addr),
        .wr_data (wr_data),
        .rd_addr (rd_addr),
        .rd_data (rd_data)
    );

    // ==========================================================================
    // data path
    // ==========================================================================
    lookup_stage u_lookup_stage (
        .clk                (clk),
        .rst_n              (rst_n),
        .phv_in             (phv_in),
        .phv_valid          (phv_valid),
        .match_addr         (match_addr),
        .if_match           (if_match),
        .ready_out          (ready_out),
        .rd_addr            (rd_addr),
        .rd_data            (rd_data),
        .action             (action),
        .action_valid       (action_valid),
        .phv_out            (phv_out),
        .ready_in           (ready_in),
        .act_vlan_out       (act_vlan_out),
        .act_vlan_out_valid (act_vlan_out_valid),
        .act_vlan_ready     (act_vlan_ready)
    );

endmodule

// File: lookup_stage.sv
module lookup_stage (
    input  logic                clk,
    input  logic                rst_n,

    input  lke_pkg::phv_t       phv_in,
    input  logic                phv_valid,
    input  lke_pkg::tbl_addr_t  match_addr,
    input  logic                if_match,
    output logic                ready_out,

    output lke_pkg::tbl_addr_t  rd_addr,
    input  lke_pkg::action_t    rd_data,

    output lke_pkg::action_t    action,
    output logic                action_valid,
    output lke_pkg::phv_t       phv_out,
    input  logic                ready_in,

    output lke_pkg::vlan_id_t   act_vlan_out,
    output logic                act_vlan_out_valid,
    input  logic                act_vlan_ready
);

    lke_pkg::lookup_state_t state;
    logic                   hit;
    logic                   accept;

    // one PHV in flight at a time
    assign ready_out = (state == lke_pkg::LK_IDLE);
    assign accept    = ready_out && phv_valid;

    // table read launched on the accept cycle
    assign rd_addr = match_addr;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state              <= lke_pkg::LK_IDLE;
            action_valid       <= 1'b0;
            act_vlan_out_valid <= 1'b0;
        end else begin
            action_valid <= 1'b0;
            case (state)
                lke_pkg::LK_IDLE: begin
                    if (accept) begin
                        act_vlan_out_valid <= act_vlan_ready;
                        state              <= lke_pkg::LK_WAIT;
                    end
                end
                lke_pkg::LK_WAIT, lke_pkg::LK_HALT: begin
                    if (ready_in) begin
                        action_valid       <= 1'b1;
                        act_vlan_out_valid <= 1'b0;
                        state              <= lke_pkg::LK_IDLE;
                    end else begin
                        state <= lke_pkg::LK_HALT;
                    end
                end
                default: begin
                    state <= lke_pkg::LK_IDLE;
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            phv_out      <= phv_in;
            hit          <= if_match;
            act_vlan_out <= phv_in[lke_pkg::VLAN_LSB +: lke_pkg::VLAN_W];
        end
        // rd_data is only good in WAIT, keep it through HALT
        if (state == lke_pkg::LK_WAIT) begin
            action <= hit ? rd_data : lke_pkg::DEFAULT_ACTION;
        end
    end

endmodule

// File: sources.f
+incdir+.
lke_pkg.sv
action_ram.sv
ctrl_filter.sv
action_entry_assembler.sv
lookup_stage.sv
lke_ram_stage.sv
tb_lke_ram_stage.sv

// File: tb_model.svh
`ifndef tb_model_svh
`define tb_model_svh

// ==========================================================================
// reference model of the action table and the forwarded control stream
// ==========================================================================
lke_pkg::action_t    model_tbl [16];
bit                  written [16];
lke_pkg::tbl_addr_t  written_list [$];

// beats expected back on c_m, with the cycle they were sent in
lke_pkg::ctrl_beat_t fwd_beats [$];
int                  fwd_cycles [$];
bit                  fwd_timed [$];

function automatic lke_pkg::action_t miss_action();
    return 625'h3f;
endfunction

// first byte on the wire ends up most significant
function automatic logic [255:0] byte_swap(input logic [255:0] d);
    logic [255:0] s;
    for (int i = 0; i < 32; i++) begin
        s[255-8*i -: 8] = d[8*i +: 8];
    end
    return s;
endfunction

// three entry beats, top down, last beat only contributes its top 113 bits
function automatic lke_pkg::action_t assemble(input logic [255:0] d0, input logic [255:0] d1,
                                              input logic [255:0] d2);
    logic [255:0] s2;
    s2 = byte_swap(d2);
    return {byte_swap(d0), byte_swap(d1), s2[255:143]};
endfunction

function automatic void store_entry(input lke_pkg::tbl_addr_t a, input lke_pkg::action_t e);
    model_tbl[a] = e;
    if (!written[a]) begin
        written_list.push_back(a);
    end
    written[a] = 1'b1;
endfunction

function automatic lke_pkg::action_t expected_action(input logic hit,
                                                     input lke_pkg::tbl_addr_t a);
    return hit ? model_tbl[a] : miss_action();
endfunction

function automatic void expect_fwd(input lke_pkg::ctrl_beat_t b, input int cyc, input bit timed);
    fwd_beats.push_back(b);
    fwd_cycles.push_back(cyc);
    fwd_timed.push_back(timed);
endfunction

`endif

// File: tb_lke_ram_stage.sv
module tb_lke_ram_stage;
    timeunit 1ns;
    timeprecision 1ps;

    logic                clk;
    logic                rst_n;
    lke_pkg::phv_t       phv_in;
    logic                phv_valid;
    lke_pkg::tbl_addr_t  match_addr;
    logic                if_match;
    logic                ready_out;
    lke_pkg::action_t    action;
    logic                action_valid;
    lke_pkg::phv_t       phv_out;
    logic                ready_in;
    lke_pkg::vlan_id_t   act_vlan_out;
    logic                act_vlan_out_valid;
    logic                act_vlan_ready;
    lke_pkg::ctrl_beat_t c_s;
    lke_pkg::ctrl_beat_t c_m;

    integer seed;
    int     cyc_cnt;
    int     errors;
    int     tests_ok;
    int     tests_bad;

    `include "tb_model.svh"

    lke_ram_stage uut (
        .clk                (clk),
        .rst_n              (rst_n),
        .phv_in             (phv_in),
        .phv_valid          (phv_valid),
        .match_addr         (match_addr),
        .if_match           (if_match),
        .ready_out          (ready_out),
        .action             (action),
        .action_valid       (action_valid),
        .phv_out            (phv_out),
        .ready_in           (ready_in),
        .act_vlan_out       (act_vlan_out),
        .act_vlan_out_valid (act_vlan_out_valid),
        .act_vlan_ready     (act_vlan_ready),
        .c_s                (c_s),
        .c_m                (c_m)
    );

    always #5 clk = ~clk;

    always @(posedge clk) begin
        cyc_cnt <= cyc_cnt + 1;
    end

    // ==========================================================================
    // helpers
    // ==========================================================================
    function automatic logic [31:0] rand32();
        return $random(seed);
    endfunction

    function automatic logic [1151:0] rand_wide();
        logic [1151:0] w;
        for (int i = 0; i < 36; i++) begin
            w[32*i +: 32] = rand32();
        end
        return w;
    endfunction

    function automatic lke_pkg::ctrl_beat_t rand_beat(input bit last);
        logic [1151:0]       w;
        lke_pkg::ctrl_beat_t b;
        w = rand_wide();
        b.tdata  = w[255:0];
        b.tuser  = w[383:256];
        b.tkeep  = w[415:384];
        b.tvalid = 1'b1;
        b.tlast  = last;
        return b;
    endfunction

    // header fields of the second beat
    function automatic lke_pkg::ctrl_beat_t set_header(input lke_pkg::ctrl_beat_t b,
            input logic [4:0] stage, input logic [2:0] lookup, input logic [15:0] flag,
            input logic [3:0] resv, input logic [7:0] index);
        b.tdata[lke_pkg::MOD_ID_LSB +: 8] = {stage, lookup};
        b.tdata[lke_pkg::RESV_LSB +: 4]   = resv;
        b.tdata[lke_pkg::FLAG_LSB +: 16]  = flag;
        b.tdata[lke_pkg::INDEX_LSB +: 8]  = index;
        return b;
    endfunction

    function automatic lke_pkg::tbl_addr_t pick_written();
        logic [31:0] r;
        r = rand32();
        return written_list[r % written_list.size()];
    endfunction

    task automatic report_mismatch(input string name, input logic [1151:0] exp,
                                   input logic [1151:0] act);
        $display("FAILED at %0d ns: %s expected %0h, actual %0h", $time, name, exp, act);
        errors++;
    endtask

    task automatic report_error(input string msg);
        $display("ERROR at %0d ns: %s", $time, msg);
        errors++;
    endtask

    task automatic end_test(input string name, input int err_start);
        if (errors == err_start) begin
            $display("test %-12s ok", name);
            tests_ok++;
        end else begin
            $display("test %-12s %0d errors", name, errors - err_start);
            tests_bad++;
        end
    endtask

    task automatic next_cycle();
        @(posedge clk);
        #1;
    endtask

    task automatic check_idle_outputs();
        if (action_valid !== 1'b0) report_mismatch("action_valid", 0, action_valid);
        if (act_vlan_out_valid !== 1'b0) begin
            report_mismatch("act_vlan_out_valid", 0, act_vlan_out_valid);
        end
        if (c_m.tvalid !== 1'b0) report_mismatch("c_m.tvalid", 0, c_m.tvalid);
        if (ready_out !== 1'b1) report_mismatch("ready_out", 1, ready_out);
    endtask

    // ==========================================================================
    // control stream
    // ==========================================================================
    task automatic drive_beat(input lke_pkg::ctrl_beat_t b);
        c_s = b;
        next_cycle();
        c_s = '0;
    endtask

    task automatic send_write(input lke_pkg::tbl_addr_t idx);
        lke_pkg::ctrl_beat_t b [5];
        logic [31:0]         r;
        r = rand32();
        b[0] = rand_beat(1'b0);
        b[1] = set_header(rand_beat(1'b0), 5'd0, 3'd2, 16'hf2f1,
                          4'd1 + r[3:0] % 4'd15, {r[7:4], idx});
        b[2] = rand_beat(1'b0);
        b[3] = rand_beat(1'b0);
        b[4] = rand_beat(1'b1);
        for (int i = 0; i < 5; i++) begin
            if (i > 0 && r[8+i]) next_cycle();
            drive_beat(b[i]);
        end
        store_entry(idx, assemble(b[2].tdata, b[3].tdata, b[4].tdata));
    endtask

    // one wrong header field sends the packet out on c_m
    task automatic send_forward();
        lke_pkg::ctrl_beat_t b;
        logic [31:0]         r;
        logic [4:0]          stage;
        logic [2:0]          lookup;
        logic [15:0]         flag;
        logic [3:0]          resv;
        int                  len;
        bit                  gapped;
        r      = rand32();
        stage  = 5'd0;
        lookup = 3'd2;
        flag   = 16'hf2f1;
        resv   = 4'd1 + r[3:0] % 4'd15;
        len    = 2 + r[5:4];
        gapped = (r[7:6] == 2'd0);
        case (r[9:8])
            2'd0: stage = 5'd1 + r[14:10] % 5'd31;
            2'd1: lookup = (r[12:10] == 3'd2) ? 3'd5 : r[12:10];
            2'd2: flag = (r[31:16] == 16'hf2f1) ? 16'hf2f0 : r[31:16];
            default: resv = 4'd0;
        endcase
        for (int i = 0; i < len; i++) begin
            b = rand_beat(i == len - 1);
            if (i == 1) b = set_header(b, stage, lookup, flag, resv, r[23:16]);
            if (gapped && i > 0 && rand32() % 2 == 0) next_cycle();
            expect_fwd(b, cyc_cnt, !gapped);
            drive_beat(b);
        end
    endtask

    task automatic wait_fwd_drain();
        int n;
        n = 0;
        while (fwd_beats.size() != 0 && n < 50) begin
            next_cycle();
            n++;
        end
        if (fwd_beats.size() != 0) begin
            report_error("timeout, forwarded beats never appeared on c_m");
            fwd_beats.delete();
            fwd_cycles.delete();
            fwd_timed.delete();
        end
    endtask

    // forwarded beats come back in order two cycles after they were sent
    always @(negedge clk) begin : fwd_monitor
        lke_pkg::ctrl_beat_t exp_b;
        int                  t0;
        bit                  timed;
        if (rst_n && c_m.tvalid) begin
            if (fwd_beats.size() == 0) begin
                report_error("beat on c_m that should have been consumed or never sent");
            end else begin
                exp_b = fwd_beats.pop_front();
                t0    = fwd_cycles.pop_front();
                timed = fwd_timed.pop_front();
                if (c_m !== exp_b) report_mismatch("c_m", exp_b, c_m);
                if (timed && cyc_cnt - t0 != 2) report_mismatch("c_m delay", 2, cyc_cnt - t0);
            end
        end
    end

    // ==========================================================================
    // data path
    // ==========================================================================
    task automatic run_lookup(input logic hit, input lke_pkg::tbl_addr_t addr,
                              input logic vlan_rdy, input int hold);
        lke_pkg::action_t  exp_act;
        lke_pkg::phv_t     phv;
        lke_pkg::vlan_id_t exp_vlan;
        logic [1151:0]     w;
        logic [31:0]       r;
        int                n;
        bit                seen;
        exp_act  = expected_action(hit, addr);
        w        = rand_wide();
        phv      = w[1123:0];
        exp_vlan = phv[140:129];
        n = 0;
        while (!ready_out && n < 20) begin
            next_cycle();
            n++;
        end
        if (!ready_out) begin
            report_error("timeout, ready_out never rose for the next PHV");
            return;
        end
        phv_in         = phv;
        phv_valid      = 1'b1;
        match_addr     = addr;
        if_match       = hit;
        act_vlan_ready = vlan_rdy;
        ready_in       = (hold == 0);
        next_cycle();
        // stage must hold what it captured while the inputs change
        w              = rand_wide();
        r              = rand32();
        phv_valid      = 1'b0;
        phv_in         = w[1123:0];
        match_addr     = r[3:0];
        if_match       = r[4];
        act_vlan_ready = r[5];
        if (ready_out !== 1'b0) report_mismatch("ready_out", 0, ready_out);
        if (act_vlan_out !== exp_vlan) report_mismatch("act_vlan_out", exp_vlan, act_vlan_out);
        if (act_vlan_out_valid !== vlan_rdy) begin
            report_mismatch("act_vlan_out_valid", vlan_rdy, act_vlan_out_valid);
        end
        seen = 1'b0;
        n    = 0;
        while (!seen && n < hold + 20) begin
            next_cycle();
            n++;
            if (action_valid) begin
                seen = 1'b1;
            end else begin
                if (ready_out !== 1'b0) report_mismatch("ready_out", 0, ready_out);
                if (act_vlan_out_valid !== vlan_rdy) begin
                    report_mismatch("act_vlan_out_valid", vlan_rdy, act_vlan_out_valid);
                end
                if (n >= hold) ready_in = 1'b1;
            end
        end
        if (!seen) begin
            report_error("timeout, no action_valid for an accepted PHV");
            return;
        end
        if (n != hold + 1) report_mismatch("action_valid cycle", hold + 1, n);
        if (action !== exp_act) report_mismatch("action", exp_act, action);
        if (phv_out !== phv) report_mismatch("phv_out", phv, phv_out);
        if (act_vlan_out !== exp_vlan) report_mismatch("act_vlan_out", exp_vlan, act_vlan_out);
        if (act_vlan_out_valid !== 1'b0) begin
            report_mismatch("act_vlan_out_valid", 0, act_vlan_out_valid);
        end
        if (ready_out !== 1'b1) report_mismatch("ready_out", 1, ready_out);
        next_cycle();
        if (action_valid !== 1'b0) report_error("action_valid stayed high past one cycle");
    endtask

    // ==========================================================================
    // test sequence
    // ==========================================================================
    initial begin : main_seq
        int          err_start;
        logic [31:0] r;
        clk            = 1'b0;
        rst_n          = 1'b0;
        phv_in         = '0;
        phv_valid      = 1'b0;
        match_addr     = '0;
        if_match       = 1'b0;
        ready_in       = 1'b1;
        act_vlan_ready = 1'b0;
        c_s            = '0;
        seed           = 32'hd9e0a3a1;
        cyc_cnt        = 0;
        errors         = 0;
        tests_ok       = 0;
        tests_bad      = 0;

        err_start = errors;
        repeat (16) begin
            next_cycle();
            check_idle_outputs();
        end
        rst_n = 1'b1;
        repeat (3) begin
            next_cycle();
            check_idle_outputs();
        end
        end_test("reset", err_start);

        err_start = errors;
        repeat (6) begin
            r = rand32();
            send_write(r[3:0]);
        end
        repeat (4) next_cycle();
        repeat (12) begin
            r = rand32();
            run_lookup(1'b1, pick_written(), r[4], 0);
        end
        end_test("write_hit", err_start);

        err_start = errors;
        repeat (10) begin
            r = rand32();
            run_lookup(1'b0, r[3:0], r[4], 0);
        end
        end_test("miss", err_start);

        err_start = errors;
        repeat (10) begin
            r = rand32();
            run_lookup(r[5], r[5] ? pick_written() : r[3:0], r[4], 1 + r[9:6] % 8);
        end
        end_test("backpressure", err_start);

        // write packets mixed in must stay off c_m
        err_start = errors;
        repeat (16) begin
            r = rand32();
            if (r[1:0] == 2'd0) begin
                send_write(r[7:4]);
            end else begin
                send_forward();
            end
            repeat (r[9:8] % 3) next_cycle();
        end
        wait_fwd_drain();
        end_test("forward", err_start);

        err_start = errors;
        repeat (3) next_cycle();
        for (int i = 0; i < 8; i++) begin
            r = rand32();
            run_lookup(r[5], r[5] ? pick_written() : r[3:0], i[0], r[7:6]);
        end
        end_test("vlan", err_start);

        $display("summary: %0d tests, %0d ok, %0d with errors, %0d errors total",
                 tests_ok + tests_bad, tests_ok, tests_bad, errors);
        if (errors == 0 && tests_bad == 0) begin
            $display("Testbench passed");
        end else begin
            $display("Testbench failed");
        end
        $finish;
    end

endmodule
